// File: src/axi_rd_defines.svh
// AXI read controller parameters

`ifndef AXI_RD_DEFINES_SVH
`define AXI_RD_DEFINES_SVH

//////////////////////////////////////////////////
// AXI side
//////////////////////////////////////////////////

`define AXI_ADDR_W   32 // byte address
`define AXI_DATA_W   64
`define AXI_ID_W     16
`define AXI_USER_W   10
`define AXI_LEN_W    8  // beats minus one

//////////////////////////////////////////////////
// SRAM side
//////////////////////////////////////////////////

`define MEM_ADDR_W   13 // word address, 8k words

// byte lanes inside one data word, log2(64/8)
`define AXI_OFFSET_W 3

`endif

// File: src/axi_rd_pkg.sv
// AXI read channel types

`default_nettype none

`include "axi_rd_defines.svh"

package axi_rd_pkg;

    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_USER_W-1:0] axi_user_t;
    typedef logic [`AXI_LEN_W-1:0]  axi_len_t; // beats minus one

    // tag is whatever lies above the SRAM window
    typedef struct packed {
        logic [`AXI_ADDR_W-`MEM_ADDR_W-`AXI_OFFSET_W-1:0] tag;
        logic [`MEM_ADDR_W-1:0]                          word_idx;
        logic [`AXI_OFFSET_W-1:0]                        offset;
    } axi_addr_fields_t;

    //////////////////////////////////////////////////
    // byte address, raw or split into fields
    //////////////////////////////////////////////////

    typedef union packed {
        logic [`AXI_ADDR_W-1:0] raw;
        axi_addr_fields_t       fields;
    } axi_addr_u;

endpackage

`default_nettype wire

// File: src/mem_pkg.sv
// SRAM port types

`default_nettype none

`include "axi_rd_defines.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t; // word address
    typedef logic [`AXI_DATA_W-1:0] mem_word_t;

    // one bit wider than the length field, so len + 1 still fits
    typedef logic [`AXI_LEN_W:0]    beat_cnt_t;

endpackage

`default_nettype wire

// File: src/rd_ctrl_if.sv
// read controller control bundle

`default_nettype none

interface rd_ctrl_if;

    // from the FSM
    logic take_req;       // AR handshake, latch the request
    logic step_beat;      // next burst word granted
    logic burst_addr_sel; // address from counter
    logic capture_q;      // register the SRAM word
    logic use_held;       // drive rdata from the holding register

    // from the counter
    logic first_is_last;  // arlen is zero
    logic last_beat;      // count has reached the stored length

    modport fsm (
        output take_req, step_beat, burst_addr_sel, capture_q, use_held,
        input  first_is_last, last_beat
    );

    modport counter (
        input  take_req, step_beat, burst_addr_sel,
        output first_is_last, last_beat
    );

    modport data (
        input take_req, capture_q, use_held
    );

endinterface

`default_nettype wire

// File: src/beat_counter.sv
// burst beat counter and SRAM address

`default_nettype none

module beat_counter (
    input  logic                  clk,
    input  logic                  rst_n,

    input  axi_rd_pkg::axi_addr_u araddr_i,
    input  axi_rd_pkg::axi_len_t  arlen_i,
    output mem_pkg::mem_addr_t    mem_a_o,

    rd_ctrl_if.counter            ctrl
);

    mem_pkg::mem_addr_t   base_q; // word index of the first beat
    axi_rd_pkg::axi_len_t len_q;
    mem_pkg::beat_cnt_t   cnt_q;  // offset of the word to request next

    assign ctrl.first_is_last = (arlen_i == '0);
    assign ctrl.last_beat     = (cnt_q == mem_pkg::beat_cnt_t'(len_q));

    // first word comes straight from the AR channel
    // later ones wrap inside the SRAM
    assign mem_a_o = ctrl.burst_addr_sel ? base_q + mem_pkg::mem_addr_t'(cnt_q)
                                         : araddr_i.fields.word_idx;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            len_q <= '0;
            cnt_q <= '0;
        end
        else if (ctrl.take_req)
        begin
            len_q <= arlen_i;
            // word 0 is read at the handshake
            cnt_q <= ctrl.first_is_last ? mem_pkg::beat_cnt_t'(0) : mem_pkg::beat_cnt_t'(1);
        end
        else if (ctrl.step_beat)
        begin
            if (ctrl.last_beat)
                cnt_q <= '0; // final word requested, ready for the next burst
            else
                cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.take_req)
            base_q <= araddr_i.fields.word_idx;
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // no step once the final word is requested, so the count stays within the length
    a_no_step_after_last : assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.step_beat |-> cnt_q != '0);

endmodule

`default_nettype wire

// File: src/rdata_hold.sv
// R channel payload registers

`default_nettype none

module rdata_hold (
    input  logic                  clk,
    input  logic                  rst_n,

    input  axi_rd_pkg::axi_id_t   arid_i,
    input  axi_rd_pkg::axi_user_t aruser_i,
    input  mem_pkg::mem_word_t    mem_q_i,

    output axi_rd_pkg::axi_id_t   rid_o,
    output axi_rd_pkg::axi_user_t ruser_o,
    output mem_pkg::mem_word_t    rdata_o,

    rd_ctrl_if.data               ctrl
);

    mem_pkg::mem_word_t held_q; // copy of the word on the bus

    //////////////////////////////////////////////////
    // id and user of the running transfer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rid_o   <= '0;
            ruser_o <= '0;
        end
        else if (ctrl.take_req)
        begin
            rid_o   <= arid_i;
            ruser_o <= aruser_i;
        end
    end

    //////////////////////////////////////////////////
    // read data
    //////////////////////////////////////////////////

    // mem_q_i is only good for one cycle, keep it in case rready is low
    always_ff @(posedge clk)
    begin
        if (ctrl.capture_q)
            held_q <= mem_q_i;
    end

    assign rdata_o = ctrl.use_held ? held_q : mem_q_i; // live word on arrival

endmodule

`default_nettype wire

// File: src/rd_fsm.sv
// read channel FSM

`default_nettype none

module rd_fsm (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  arvalid_i,
    output logic  arready_o,

    output logic  rvalid_o,
    output logic  rlast_o,
    input  logic  rready_i,

    output logic  mem_req_o,
    output logic  mem_cen_o,
    input  logic  mem_gnt_i,

    rd_ctrl_if.fsm ctrl
);

    typedef enum logic [2:0] {
        st_idle,
        st_single,           // single word on the bus
        st_wait_single,      // single word held, rready low
        st_burst,            // burst word on the bus
        st_wait_burst_grant, // beat accepted, next word not granted yet
        st_wait_burst_ready, // burst word held, rready low
        st_last,             // final burst word on the bus
        st_wait_last         // final word held, rready low
    } state_e;

    state_e state_q, state_d;

    logic open_ar;   // AR channel may take a new request
    logic next_beat; // ask for the next word of the burst

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    //////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////

    always_comb
    begin
        state_d             = state_q;
        arready_o           = 1'b0;
        rvalid_o            = 1'b0;
        rlast_o             = 1'b0;
        mem_req_o           = 1'b0;
        ctrl.take_req       = 1'b0;
        ctrl.step_beat      = 1'b0;
        ctrl.burst_addr_sel = 1'b0;
        ctrl.capture_q      = 1'b0;
        ctrl.use_held       = 1'b0;
        open_ar             = 1'b0;
        next_beat           = 1'b0;

        case (state_q)
            st_idle:
                open_ar = 1'b1;

            st_single, st_last:
            begin
                rvalid_o       = 1'b1;
                rlast_o        = 1'b1;
                ctrl.capture_q = 1'b1; // word only lives this cycle
                if (rready_i)
                    open_ar = 1'b1;
                else if (state_q == st_single)
                    state_d = st_wait_single;
                else
                    state_d = st_wait_last;
            end

            st_wait_single, st_wait_last:
            begin
                rvalid_o      = 1'b1;
                rlast_o       = 1'b1;
                ctrl.use_held = 1'b1;
                open_ar       = rready_i;
            end

            st_burst:
            begin
                rvalid_o            = 1'b1;
                ctrl.capture_q      = 1'b1;
                ctrl.burst_addr_sel = 1'b1;
                if (rready_i)
                    next_beat = 1'b1;
                else
                    state_d = st_wait_burst_ready;
            end

            st_wait_burst_ready:
            begin
                rvalid_o            = 1'b1;
                ctrl.use_held       = 1'b1;
                ctrl.burst_addr_sel = 1'b1;
                next_beat           = rready_i;
            end

            st_wait_burst_grant:
            begin
                ctrl.burst_addr_sel = 1'b1;
                next_beat           = 1'b1; // nothing on R, keep asking
            end

            default:
                state_d = st_idle;
        endcase

        // current beat is done, the next word must be granted first
        if (next_beat)
        begin
            mem_req_o = 1'b1;
            if (mem_gnt_i)
            begin
                ctrl.step_beat = 1'b1;
                state_d        = ctrl.last_beat ? st_last : st_burst;
            end
            else
                state_d = st_wait_burst_grant;
        end

        // AR handshake also issues the first SRAM read
        if (open_ar)
        begin
            mem_req_o     = arvalid_i;
            arready_o     = arvalid_i & mem_gnt_i;
            ctrl.take_req = arvalid_i & mem_gnt_i;
            if (ctrl.take_req)
                state_d = ctrl.first_is_last ? st_single : st_burst;
            else
                state_d = st_idle;
        end
    end

    assign mem_cen_o = ~mem_req_o; // SRAM enable is active low

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_rvalid_held : assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_o && !rready_i |=> rvalid_o);

    a_rlast_stable : assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_o && !rready_i |=> $stable(rlast_o));

endmodule

`default_nettype wire

// File: src/axi_rd_mem_ctrl.sv
// AXI4 read-only SRAM controller

`default_nettype none

module axi_rd_mem_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,

    // read address channel
    input  axi_rd_pkg::axi_id_t   arid_i,
    input  axi_rd_pkg::axi_addr_u araddr_i,
    input  axi_rd_pkg::axi_len_t  arlen_i,
    input  axi_rd_pkg::axi_user_t aruser_i,
    input  logic                  arvalid_i,
    output logic                  arready_o,

    // read data channel
    output axi_rd_pkg::axi_id_t   rid_o,
    output mem_pkg::mem_word_t    rdata_o,
    output logic                  rlast_o,
    output axi_rd_pkg::axi_user_t ruser_o,
    output logic                  rvalid_o,
    input  logic                  rready_i,

    // SRAM port behind the arbiter
    output logic                  mem_cen_o,
    output mem_pkg::mem_addr_t    mem_a_o,
    input  mem_pkg::mem_word_t    mem_q_i,
    output logic                  mem_req_o,
    input  logic                  mem_gnt_i
);

    rd_ctrl_if ctrl ();

    rd_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rvalid_o  (rvalid_o),
        .rlast_o   (rlast_o),
        .rready_i  (rready_i),
        .mem_req_o (mem_req_o),
        .mem_cen_o (mem_cen_o),
        .mem_gnt_i (mem_gnt_i),
        .ctrl      (ctrl.fsm)
    );

    // address generation for the SRAM
    beat_counter u_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .araddr_i (araddr_i),
        .arlen_i  (arlen_i),
        .mem_a_o  (mem_a_o),
        .ctrl     (ctrl.counter)
    );

    rdata_hold u_hold (
        .clk      (clk),
        .rst_n    (rst_n),
        .arid_i   (arid_i),
        .aruser_i (aruser_i),
        .mem_q_i  (mem_q_i),
        .rid_o    (rid_o),
        .ruser_o  (ruser_o),
        .rdata_o  (rdata_o),
        .ctrl     (ctrl.data)
    );

endmodule

`default_nettype wire

// File: tests/tb_axi_rd_mem_ctrl.sv
// AXI read controller testbench

`default_nettype none

`include "axi_rd_defines.svh"

module tb_axi_rd_mem_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_beats      = 8 + 136 + 3 * 8 * 16; // upper bound over all tests
    localparam int timeout_cycles = max_beats * 20 + 200;

    typedef struct packed {
        axi_rd_pkg::axi_id_t   id;
        axi_rd_pkg::axi_user_t user;
        mem_pkg::mem_word_t    data;
        logic                  last;
    } beat_t;

    logic                  clk;
    logic                  rst_n;
    axi_rd_pkg::axi_id_t   arid_i;
    axi_rd_pkg::axi_addr_u araddr_i;
    axi_rd_pkg::axi_len_t  arlen_i;
    axi_rd_pkg::axi_user_t aruser_i;
    logic                  arvalid_i;
    logic                  arready_o;
    axi_rd_pkg::axi_id_t   rid_o;
    mem_pkg::mem_word_t    rdata_o;
    logic                  rlast_o;
    axi_rd_pkg::axi_user_t ruser_o;
    logic                  rvalid_o;
    logic                  rready_i;
    logic                  mem_cen_o;
    mem_pkg::mem_addr_t    mem_a_o;
    mem_pkg::mem_word_t    mem_q_i;
    logic                  mem_req_o;
    logic                  mem_gnt_i;

    beat_t exp_q[$];   // beats still owed by the DUT
    int    errors;
    int    beats;
    int    cycles;
    int    errors_start;
    int    beats_start;
    logic  gnt_rand;
    logic  rready_rand;
    logic  ar_gaps;    // idle cycles between requests
    logic  stall_q;    // last cycle had rvalid without rready
    beat_t held;       // R payload seen in that cycle
    mem_pkg::mem_word_t mem_word; // SRAM output for the coming cycle

    axi_rd_mem_ctrl dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected SRAM content, address above and its inverse below
    function automatic mem_pkg::mem_word_t ref_word(input mem_pkg::mem_addr_t addr);
        logic [`AXI_DATA_W/2-1:0] half;
        half = {{(`AXI_DATA_W/2-`MEM_ADDR_W){1'b0}}, addr};
        return {half, ~half};
    endfunction

    //////////////////////////////////////////////////
    // SRAM and arbiter models
    //////////////////////////////////////////////////

    // read needs the request, the grant and the enable
    always @(posedge clk)
    begin
        if (mem_req_o && mem_gnt_i && !mem_cen_o)
            mem_word <= ref_word(mem_a_o);
        else
            mem_word <= {(`AXI_DATA_W/16){16'hdead}}; // word lives one cycle only
    end

    always @(negedge clk)
    begin
        mem_q_i   = mem_word;
        mem_gnt_i = gnt_rand ? ($urandom % 4 != 0) : 1'b1;
        rready_i  = rready_rand ? ($urandom % 3 != 0) : 1'b1;
    end

    task automatic value_error(input string name, input logic [63:0] want, input logic [63:0] got);
        $display("[ERROR] %s expected %h got %h", name, want, got);
        errors++;
    endtask

    //////////////////////////////////////////////////
    // comparing process
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin : compare
        beat_t want;
        if (rst_n)
        begin
            if (stall_q)
            begin
                if (rvalid_o !== 1'b1)
                    value_error("rvalid_o", 1, rvalid_o);
                if (rdata_o !== held.data)
                    value_error("rdata_o", held.data, rdata_o);
                if (rid_o !== held.id)
                    value_error("rid_o", held.id, rid_o);
                if (ruser_o !== held.user)
                    value_error("ruser_o", held.user, ruser_o);
                if (rlast_o !== held.last)
                    value_error("rlast_o", held.last, rlast_o);
            end
            if (rvalid_o && rready_i)
            begin
                beats++;
                if (exp_q.size() == 0)
                begin
                    $display("[ERROR] a beat with id %h came when none was expected", rid_o);
                    errors++;
                end
                else
                begin
                    want = exp_q.pop_front();
                    if (rdata_o !== want.data)
                        value_error("rdata_o", want.data, rdata_o);
                    if (rid_o !== want.id)
                        value_error("rid_o", want.id, rid_o);
                    if (ruser_o !== want.user)
                        value_error("ruser_o", want.user, ruser_o);
                    if (rlast_o !== want.last)
                        value_error("rlast_o", want.last, rlast_o);
                end
            end
            if (arready_o && !mem_gnt_i)
            begin
                $display("[ERROR] arready_o was high while the grant was low");
                errors++;
            end
            // no SRAM access while the R channel is stalled
            if (rvalid_o && !rready_i)
            begin
                if (mem_req_o !== 1'b0)
                    value_error("mem_req_o", 0, mem_req_o);
                if (mem_cen_o !== 1'b1)
                    value_error("mem_cen_o", 1, mem_cen_o);
            end
            // word index wraps inside the SRAM
            if (arvalid_i && arready_o)
                for (int k = 0; k <= int'(arlen_i); k++)
                    exp_q.push_back({arid_i, aruser_i,
                        ref_word(araddr_i.fields.word_idx + mem_pkg::mem_addr_t'(k)),
                        k == int'(arlen_i)});
        end
        stall_q = rvalid_o && !rready_i;
        held    = {rid_o, ruser_o, rdata_o, rlast_o};
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // called on a falling edge, returns on the falling edge after the AR handshake
    task automatic issue_req(input axi_rd_pkg::axi_addr_u addr, input axi_rd_pkg::axi_len_t len);
        int gap;
        gap = ar_gaps ? $urandom % 3 : 0;
        if (gap > 0)
        begin
            arvalid_i = 1'b0;
            repeat (gap) @(negedge clk);
        end
        arid_i    = $urandom;
        aruser_i  = $urandom;
        araddr_i  = addr;
        arlen_i   = len;
        arvalid_i = 1'b1;
        do
            @(posedge clk);
        while (!(arvalid_i && arready_o));
        @(negedge clk);
    endtask

    task automatic random_reads(input int count, input int len_mod);
        axi_rd_pkg::axi_addr_u addr;
        for (int i = 0; i < count; i++)
        begin
            addr.raw = $urandom;
            issue_req(addr, axi_rd_pkg::axi_len_t'($urandom % len_mod));
        end
    endtask

    task automatic start_test(input logic gnt_r, input logic rdy_r, input logic gaps);
        gnt_rand     = gnt_r;
        rready_rand  = rdy_r;
        ar_gaps      = gaps;
        errors_start = errors;
        beats_start  = beats;
    endtask

    task automatic finish_test(input string name);
        arvalid_i = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk); // room for a stray beat
        $display("test %-16s beats %0d errors %0d", name, beats - beats_start,
                 errors - errors_start);
    endtask

    initial
    begin
        axi_rd_pkg::axi_addr_u addr;
        void'($urandom(32'h9236));
        errors = 0;
        beats = 0;
        cycles = 0;
        stall_q = 1'b0;
        held = '0;
        gnt_rand = 1'b0;
        rready_rand = 1'b0;
        ar_gaps = 1'b0;
        rst_n = 1'b0;
        arid_i = '0;
        araddr_i = '0;
        arlen_i = '0;
        aruser_i = '0;
        arvalid_i = 1'b0;
        rready_i = 1'b1;
        mem_gnt_i = 1'b1;
        mem_q_i = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test(1'b0, 1'b0, 1'b0);
        @(negedge clk);
        if (rvalid_o !== 1'b0)
            value_error("rvalid_o", 0, rvalid_o);
        if (rlast_o !== 1'b0)
            value_error("rlast_o", 0, rlast_o);
        if (arready_o !== 1'b0)
            value_error("arready_o", 0, arready_o);
        if (mem_req_o !== 1'b0)
            value_error("mem_req_o", 0, mem_req_o);
        if (mem_cen_o !== 1'b1)
            value_error("mem_cen_o", 1, mem_cen_o);
        finish_test("reset state");

        start_test(1'b0, 1'b0, 1'b1);
        random_reads(8, 1);
        finish_test("single reads");

        // lengths 1 to 16, the longest ones cross the top of the SRAM
        start_test(1'b0, 1'b0, 1'b1);
        for (int len = 0; len < 16; len++)
        begin
            addr.raw = $urandom;
            if (len >= 12)
                addr.fields.word_idx = mem_pkg::mem_addr_t'(-(len - 8));
            issue_req(addr, axi_rd_pkg::axi_len_t'(len));
        end
        finish_test("bursts");

        start_test(1'b0, 1'b1, 1'b1);
        random_reads(8, 16);
        finish_test("rready stalls");

        start_test(1'b1, 1'b0, 1'b1);
        random_reads(8, 16);
        finish_test("grant stalls");

        start_test(1'b1, 1'b1, 1'b0);
        random_reads(8, 16);
        finish_test("back to back");

        $display("beats %0d errors %0d cycles %0d", beats, errors, cycles);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/axi_rd_pkg.sv
src/mem_pkg.sv
src/rd_ctrl_if.sv
src/beat_counter.sv
src/rdata_hold.sv
src/rd_fsm.sv
src/axi_rd_mem_ctrl.sv
tests/tb_axi_rd_mem_ctrl.sv

// File: Makefile
# Verilator flow for the AXI read controller

TOP = tb_axi_rd_mem_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)

obj_dir/sim: flist.f src/*.sv src/*.svh tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f flist.f --top-module $(TOP) -o sim

# pass only when the testbench printed the pass line
sim: obj_dir/sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
